//--- hw/io_map_pkg.sv
`default_nettype none

// Address map of the memory-mapped I/O window.
// All devices sit at word addresses near the top of the 32-bit space.
package io_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////////////

  // Address and data share one width on this bus
  localparam int IO_ADDR_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Write side devices
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [IO_ADDR_W-1:0] IO_SEG_ADDR   = 32'hFFFF_FF00;
  localparam logic [IO_ADDR_W-1:0] IO_LED_ADDR   = 32'hFFFF_FF04;
  localparam logic [IO_ADDR_W-1:0] IO_BLINK_ADDR = 32'hFFFF_FF08;

  ////////////////////////////////////////////////////////////////////////////
  // Read side devices
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [IO_ADDR_W-1:0] IO_A_ADDR    = 32'hFFFF_FF10;
  localparam logic [IO_ADDR_W-1:0] IO_B_ADDR    = 32'hFFFF_FF14;
  localparam logic [IO_ADDR_W-1:0] IO_TEST_ADDR = 32'hFFFF_FF18;

  // Which input device drives read data
  typedef enum logic [1:0] {
    RD_NONE,
    RD_A,
    RD_B,
    RD_TEST
  } io_rd_sel_t;

endpackage

`default_nettype wire

//--- hw/io_timing_pkg.sv
`default_nettype none

// Device sizes and display timing for the I/O block
package io_timing_pkg;

  // Seven-segment pattern, one bit per segment over all digits
  localparam int SEG_W = 24;

  // Segment queue geometry
  localparam int SEG_QUEUE_DEPTH = 32;
  localparam int SEG_PTR_W       = 5;

  // Dwell per pattern, kept short so simulation stays quick
  localparam int SEG_DWELL_CYCLES = 16;
  localparam int SEG_DWELL_W      = $clog2(SEG_DWELL_CYCLES);

  // LED bank
  localparam int LED_W = 16;

  // Operand latches and test switches
  localparam int AB_W   = 8;
  localparam int TEST_W = 3;

endpackage

`default_nettype wire

//--- hw/io_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Address decode for the I/O window.
// Writes become one-cycle enables, reads become a device select.
module io_addr_decode
  import io_map_pkg::*;
(
  input  wire logic                 io_we,
  input  wire logic [IO_ADDR_W-1:0] io_addr,
  output logic                      seg_wr,
  output logic                      led_wr,
  output logic                      blink_wr,
  output io_rd_sel_t                rd_sel
);

  ////////////////////////////////////////////////////////////////////////////
  // Write enables
  ////////////////////////////////////////////////////////////////////////////

  assign seg_wr   = io_we && (io_addr == IO_SEG_ADDR);
  assign led_wr   = io_we && (io_addr == IO_LED_ADDR);
  assign blink_wr = io_we && (io_addr == IO_BLINK_ADDR);

  ////////////////////////////////////////////////////////////////////////////
  // Read select
  ////////////////////////////////////////////////////////////////////////////

  // A write cycle never reads a device
  always_comb begin
    rd_sel = RD_NONE;
    if (!io_we) begin
      case (io_addr)
        IO_A_ADDR:    rd_sel = RD_A;
        IO_B_ADDR:    rd_sel = RD_B;
        IO_TEST_ADDR: rd_sel = RD_TEST;
        default:      rd_sel = RD_NONE;
      endcase
    end
  end

  // Write addresses in the map must be distinct
  always_comb begin
    assert ($onehot0({seg_wr, led_wr, blink_wr}))
      else $error("io_addr_decode: more than one write enable at %h", io_addr);
  end

endmodule

`default_nettype wire

//--- hw/seg_display_queue.sv
`timescale 1ns/1ps
`default_nettype none

// Circular queue of seven-segment patterns.
// The head pattern is shown for a fixed dwell, then popped.
module seg_display_queue
  import io_timing_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             seg_wr,
  input  wire logic [SEG_W-1:0] seg_data,
  output logic      [SEG_W-1:0] seg_out
);

  logic [SEG_W-1:0]       mem [SEG_QUEUE_DEPTH];
  logic [SEG_PTR_W-1:0]   front;
  logic [SEG_PTR_W-1:0]   back;
  logic [SEG_PTR_W:0]     count;
  logic [SEG_DWELL_W-1:0] dwell;

  logic empty;
  logic full;
  logic push;
  logic pop;

  ////////////////////////////////////////////////////////////////////////////
  // Queue status
  ////////////////////////////////////////////////////////////////////////////

  assign empty = (count == '0);
  assign full  = (count == (SEG_PTR_W + 1)'(SEG_QUEUE_DEPTH));

  // No back-pressure, so a write into a full queue is lost
  assign push = seg_wr && !full;

  // Head leaves on the last cycle of its dwell
  assign pop = !empty && (dwell == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Pattern storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[back] <= seg_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, occupancy and dwell
  ////////////////////////////////////////////////////////////////////////////

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      front <= '0;
      back  <= '0;
      count <= '0;
      dwell <= SEG_DWELL_W'(SEG_DWELL_CYCLES - 1);
    end else begin
      if (push) begin
        back <= back + 1'b1;
      end
      if (pop) begin
        front <= front + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // Held at full dwell while idle, so a fresh entry gets its whole slot
      if (empty || pop) begin
        dwell <= SEG_DWELL_W'(SEG_DWELL_CYCLES - 1);
      end else begin
        dwell <= dwell - 1'b1;
      end
    end
  end

  // Head entry, blank when nothing is queued
  assign seg_out = empty ? '0 : mem[front];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_count_bound : assert property (@(posedge clk) disable iff (rst)
    count <= (SEG_PTR_W + 1)'(SEG_QUEUE_DEPTH))
    else $error("seg_display_queue: count %0d above depth", count);

  // An empty queue has its pointers together
  a_ptrs_when_empty : assert property (@(posedge clk) disable iff (rst)
    (count == '0) |-> (front == back))
    else $error("seg_display_queue: front %0d back %0d with empty queue", front, back);

endmodule

`default_nettype wire

//--- hw/led_blink_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// LED register and blink timer.
// A blink write of V keeps blink_out high for V cycles.
module led_blink_ctrl
  import io_map_pkg::*;
  import io_timing_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 led_wr,
  input  wire logic                 blink_wr,
  input  wire logic [IO_ADDR_W-1:0] wdata,
  output logic      [LED_W-1:0]     led_out,
  output logic                      blink_out
);

  logic [IO_ADDR_W-1:0] blink_cnt;
  logic [IO_ADDR_W-1:0] blink_next;

  ////////////////////////////////////////////////////////////////////////////
  // LED register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      led_out <= '0;
    end else if (led_wr) begin
      led_out <= wdata[LED_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Blink countdown
  ////////////////////////////////////////////////////////////////////////////

  // A write restarts the count, and zero stops it at once
  always_comb begin
    if (blink_wr) begin
      blink_next = wdata;
    end else if (blink_cnt != '0) begin
      blink_next = blink_cnt - 1'b1;
    end else begin
      blink_next = '0;
    end
  end

  // Output follows the new count so it stays high for exactly V cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      blink_cnt <= '0;
      blink_out <= 1'b0;
    end else begin
      blink_cnt <= blink_next;
      blink_out <= (blink_next != '0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_blink_reset : assert property (@(posedge clk)
    rst |=> !blink_out)
    else $error("led_blink_ctrl: blink_out high after reset");

endmodule

`default_nettype wire

//--- hw/io_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

// Input devices and read data path.
// Operand latches capture ab_in on their strobes.
module io_read_mux
  import io_map_pkg::*;
  import io_timing_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 enter_a,
  input  wire logic                 enter_b,
  input  wire logic [AB_W-1:0]      ab_in,
  input  wire logic [TEST_W-1:0]    test_in,
  input  wire io_rd_sel_t           rd_sel,
  output logic      [IO_ADDR_W-1:0] rdata
);

  logic [AB_W-1:0] a_reg;
  logic [AB_W-1:0] b_reg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand latches
  ////////////////////////////////////////////////////////////////////////////

  // Both strobes together load the same value into both
  always_ff @(posedge clk) begin
    if (rst) begin
      a_reg <= '0;
      b_reg <= '0;
    end else begin
      if (enter_a) begin
        a_reg <= ab_in;
      end
      if (enter_b) begin
        b_reg <= ab_in;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Zero-extended to bus width
  always_comb begin
    case (rd_sel)
      RD_A:    rdata = {{(IO_ADDR_W - AB_W){1'b0}}, a_reg};
      RD_B:    rdata = {{(IO_ADDR_W - AB_W){1'b0}}, b_reg};
      RD_TEST: rdata = {{(IO_ADDR_W - TEST_W){1'b0}}, test_in};
      default: rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/mem_io_top.sv
`timescale 1ns/1ps
`default_nettype none

// Memory-mapped I/O block on the data-memory bus.
// Decode feeds the output devices and the read path.
module mem_io_top
  import io_map_pkg::*;
  import io_timing_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,

  // Data-memory bus
  input  wire logic                 io_we,
  input  wire logic [IO_ADDR_W-1:0] io_addr,
  input  wire logic [IO_ADDR_W-1:0] io_wdata,
  output logic      [IO_ADDR_W-1:0] io_rdata,

  // Board inputs
  input  wire logic                 enter_a,
  input  wire logic                 enter_b,
  input  wire logic [AB_W-1:0]      ab_in,
  input  wire logic [TEST_W-1:0]    test_in,

  // Board outputs
  output logic      [SEG_W-1:0]     seg_out,
  output logic      [LED_W-1:0]     led_out,
  output logic                      blink_out
);

  logic       seg_wr;
  logic       led_wr;
  logic       blink_wr;
  io_rd_sel_t rd_sel;

  io_addr_decode u_decode (
    .io_we    (io_we),
    .io_addr  (io_addr),
    .seg_wr   (seg_wr),
    .led_wr   (led_wr),
    .blink_wr (blink_wr),
    .rd_sel   (rd_sel)
  );

  // Only the low bits of the write data carry a pattern
  seg_display_queue u_seg_queue (
    .clk      (clk),
    .rst      (rst),
    .seg_wr   (seg_wr),
    .seg_data (io_wdata[SEG_W-1:0]),
    .seg_out  (seg_out)
  );

  led_blink_ctrl u_led_blink (
    .clk       (clk),
    .rst       (rst),
    .led_wr    (led_wr),
    .blink_wr  (blink_wr),
    .wdata     (io_wdata),
    .led_out   (led_out),
    .blink_out (blink_out)
  );

  io_read_mux u_read_mux (
    .clk     (clk),
    .rst     (rst),
    .enter_a (enter_a),
    .enter_b (enter_b),
    .ab_in   (ab_in),
    .test_in (test_in),
    .rd_sel  (rd_sel),
    .rdata   (io_rdata)
  );

endmodule

`default_nettype wire

//--- tb/tb_mem_io.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the memory-mapped I/O block.
// Reference models run beside the DUT and assertions compare every cycle.
module tb_mem_io
  import io_map_pkg::*;
  import io_timing_pkg::*;
();

  logic                 clk;
  logic                 rst;
  logic                 io_we;
  logic [IO_ADDR_W-1:0] io_addr;
  logic [IO_ADDR_W-1:0] io_wdata;
  logic [IO_ADDR_W-1:0] io_rdata;
  logic                 enter_a;
  logic                 enter_b;
  logic [AB_W-1:0]      ab_in;
  logic [TEST_W-1:0]    test_in;
  logic [SEG_W-1:0]     seg_out;
  logic [LED_W-1:0]     led_out;
  logic                 blink_out;

  // Reference model state
  logic [LED_W-1:0]     m_led;
  logic [IO_ADDR_W-1:0] m_blink;
  logic [AB_W-1:0]      m_a;
  logic [AB_W-1:0]      m_b;
  logic [SEG_W-1:0]     m_q[$];
  int                   m_age;
  logic [SEG_W-1:0]     exp_seg;
  logic                 exp_blink;
  logic [IO_ADDR_W-1:0] exp_rdata;

  logic [31:0] rng_state;
  string       cur_test;

  mem_io_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .io_we     (io_we),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_rdata  (io_rdata),
    .enter_a   (enter_a),
    .enter_b   (enter_b),
    .ab_in     (ab_in),
    .test_in   (test_in),
    .seg_out   (seg_out),
    .led_out   (led_out),
    .blink_out (blink_out)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and random numbers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %s %s expected %h actual %h", cur_test, sig, expected, actual);
    stop_with_failure();
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : led_blink_model
    if (rst) begin
      m_led   <= '0;
      m_blink <= '0;
    end else begin
      if (io_we && io_addr == IO_LED_ADDR) begin
        m_led <= io_wdata[LED_W-1:0];
      end
      // Remaining high cycles of the blink output
      if (io_we && io_addr == IO_BLINK_ADDR) begin
        m_blink <= io_wdata;
      end else if (m_blink != '0) begin
        m_blink <= m_blink - 32'd1;
      end
    end
  end

  always @(posedge clk) begin : latch_model
    if (rst) begin
      m_a <= '0;
      m_b <= '0;
    end else begin
      if (enter_a) begin
        m_a <= ab_in;
      end
      if (enter_b) begin
        m_b <= ab_in;
      end
    end
  end

  // m_age counts the cycles the head has been on display
  always @(posedge clk) begin : seg_model
    logic accept;
    logic do_pop;
    if (rst) begin
      m_q.delete();
      m_age = 0;
      exp_seg <= '0;
    end else begin
      accept = io_we && (io_addr == IO_SEG_ADDR) && (m_q.size() < SEG_QUEUE_DEPTH);
      do_pop = (m_q.size() != 0) && (m_age == SEG_DWELL_CYCLES);
      if (do_pop) begin
        void'(m_q.pop_front());
        m_age = 0;
      end
      if (accept) begin
        m_q.push_back(io_wdata[SEG_W-1:0]);
      end
      if (m_q.size() != 0) begin
        m_age = m_age + 1;
      end else begin
        m_age = 0;
      end
      exp_seg <= (m_q.size() != 0) ? m_q[0] : '0;
    end
  end

  assign exp_blink = (m_blink != '0);

  // Reads see the latches and switches in the same cycle
  always_comb begin
    exp_rdata = '0;
    if (!io_we) begin
      if (io_addr == IO_A_ADDR) begin
        exp_rdata = 32'(m_a);
      end else if (io_addr == IO_B_ADDR) begin
        exp_rdata = 32'(m_b);
      end else if (io_addr == IO_TEST_ADDR) begin
        exp_rdata = 32'(test_in);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks against the models
  ////////////////////////////////////////////////////////////////////////////

  a_led_match : assert property (@(posedge clk) disable iff (rst) led_out == m_led)
    else report_mismatch("led_out", 32'($sampled(m_led)), 32'($sampled(led_out)));

  a_blink_match : assert property (@(posedge clk) disable iff (rst) blink_out == exp_blink)
    else report_mismatch("blink_out", 32'($sampled(exp_blink)), 32'($sampled(blink_out)));

  a_seg_match : assert property (@(posedge clk) disable iff (rst) seg_out == exp_seg)
    else report_mismatch("seg_out", 32'($sampled(exp_seg)), 32'($sampled(seg_out)));

  a_rdata_match : assert property (@(posedge clk) disable iff (rst) io_rdata == exp_rdata)
    else report_mismatch("io_rdata", $sampled(exp_rdata), $sampled(io_rdata));

  ////////////////////////////////////////////////////////////////////////////
  // Bus and wait tasks
  ////////////////////////////////////////////////////////////////////////////

  // Called right after a rising edge, returns after the write edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    io_we    <= 1'b1;
    io_addr  <= addr;
    io_wdata <= data;
    @(posedge clk);
  endtask

  task automatic bus_idle();
    io_we   <= 1'b0;
    io_addr <= 32'h0000_0000;
    @(posedge clk);
  endtask

  task automatic wait_blink_low(input int limit);
    int n;
    n = 0;
    while (blink_out && n < limit) begin
      bus_idle();
      n++;
    end
    if (blink_out) begin
      $display("Timeout: blink_out stayed high for %0d cycles", limit);
      stop_with_failure();
    end
  endtask

  task automatic wait_seg_empty(input int limit);
    int n;
    n = 0;
    while (seg_out != '0 && n < limit) begin
      bus_idle();
      n++;
    end
    if (seg_out != '0) begin
      $display("Timeout: segment queue did not drain in %0d cycles", limit);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] seg_pattern();
    return (next_random() & 32'h00FF_FFFF) | 32'h0000_0001;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    io_addr <= IO_A_ADDR;
    @(posedge clk);
    assert (seg_out == '0) else report_mismatch("seg_out", 32'h0, 32'(seg_out));
    assert (led_out == '0) else report_mismatch("led_out", 32'h0, 32'(led_out));
    assert (!blink_out) else report_mismatch("blink_out", 32'h0, 32'(blink_out));
    assert (io_rdata == '0) else report_mismatch("io_rdata A", 32'h0, io_rdata);
    io_addr <= IO_B_ADDR;
    @(posedge clk);
    assert (io_rdata == '0) else report_mismatch("io_rdata B", 32'h0, io_rdata);
  endtask

  task automatic run_led_test();
    logic [31:0] r;
    cur_test = "led";
    for (int i = 0; i < 24; i++) begin
      r = next_random();
      case (r[1:0])
        2'd0:    bus_write(32'h0000_1000 | (r & 32'h0000_0FFC), next_random());
        2'd1:    bus_write(IO_A_ADDR, next_random());
        default: bus_write(IO_LED_ADDR, next_random());
      endcase
    end
    bus_idle();
  endtask

  task automatic run_blink_test();
    cur_test = "blink";
    for (int i = 0; i < 6; i++) begin
      bus_write(IO_BLINK_ADDR, 32'd1 + (next_random() % 32'd12));
      bus_idle();
      wait_blink_low(64);
    end
    // Zero write ends a long blink early
    bus_write(IO_BLINK_ADDR, 32'd40);
    repeat (5) bus_idle();
    bus_write(IO_BLINK_ADDR, 32'd0);
    bus_idle();
    // Rewrite mid-count restarts it
    bus_write(IO_BLINK_ADDR, 32'd10);
    repeat (4) bus_idle();
    bus_write(IO_BLINK_ADDR, 32'd10);
    wait_blink_low(64);
  endtask

  task automatic run_seg_test();
    cur_test = "seg burst";
    repeat (5) bus_write(IO_SEG_ADDR, seg_pattern());
    wait_seg_empty(SEG_DWELL_CYCLES * 8);
    cur_test = "seg write on pop";
    bus_write(IO_SEG_ADDR, seg_pattern());
    repeat (SEG_DWELL_CYCLES - 1) bus_idle();
    bus_write(IO_SEG_ADDR, seg_pattern());
    bus_write(IO_SEG_ADDR, seg_pattern());
    for (int i = 0; i < 12; i++) begin
      repeat (next_random() % 32'd20) bus_idle();
      bus_write(IO_SEG_ADDR, seg_pattern());
    end
    wait_seg_empty(SEG_DWELL_CYCLES * 20);
    cur_test = "seg overflow";
    repeat (40) bus_write(IO_SEG_ADDR, seg_pattern());
    wait_seg_empty(SEG_DWELL_CYCLES * (SEG_QUEUE_DEPTH + 4));
  endtask

  task automatic run_read_test();
    logic [31:0] r;
    cur_test = "read";
    for (int i = 0; i < 60; i++) begin
      r = next_random();
      ab_in   <= r[7:0];
      enter_a <= r[8];
      enter_b <= r[9];
      test_in <= r[12:10];
      io_we   <= r[13] & r[14];
      case (r[17:16])
        2'd0:    io_addr <= IO_A_ADDR;
        2'd1:    io_addr <= IO_B_ADDR;
        2'd2:    io_addr <= IO_TEST_ADDR;
        default: io_addr <= 32'h0000_2000 | (r & 32'h0000_0FFC);
      endcase
      @(posedge clk);
    end
    enter_a <= 1'b0;
    enter_b <= 1'b0;
    bus_idle();
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    io_we     = 1'b0;
    io_addr   = '0;
    io_wdata  = '0;
    enter_a   = 1'b0;
    enter_b   = 1'b0;
    ab_in     = '0;
    test_in   = '0;
    rng_state = 32'd87893;
    cur_test  = "reset";
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    check_reset_state();
    run_led_test();
    run_blink_test();
    run_seg_test();
    run_read_test();
    repeat (4) bus_idle();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hw/io_map_pkg.sv
hw/io_timing_pkg.sv
hw/io_addr_decode.sv
hw/seg_display_queue.sv
hw/led_blink_ctrl.sv
hw/io_read_mux.sv
hw/mem_io_top.sv
tb/tb_mem_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I/O block testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_io -f tb.f \
  --Mdir obj_dir -o sim_tb_mem_io
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb_mem_io 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
